// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# A $fatal in the testbench gives a nonzero exit status, which fails this target
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: src/icache_ctrl.sv
// Lookup FSM: accepts CPU fetches, checks tags, reads hits or waits on refill, formats data

`timescale 1ns/10ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic      mclk,
    input  logic      rst_n,
    // CPU side
    input  logic      cpu_req_i,       // Level, held until ack
    input  cpu_req_t  cpu_req_data_i,
    output logic      cpu_req_ack_o,
    output logic      cpu_resp_o,      // One-cycle response strobe
    output word_t     cpu_rdata_o,
    // Tag store
    output tag_t      cmp_tag_o,
    input  logic      hit_i,
    input  line_idx_t hit_idx_i,
    // Refill engine
    output logic      refill_start_o,
    output addr_t     refill_addr_o,
    input  logic      refill_busy_i,
    // Data array
    output ram_addr_t ram_raddr_o,
    input  word_t     ram_rdata_i
);

    ctrl_state_e state;
    cpu_req_t    req_q;                // Request being served
    ram_addr_t   raddr_q;              // Array read address of the hit word
    word_t       rdata_q;              // Last returned data
    word_t       rdata_fmt;

    // Lane select by width and low address bits, zero-extended
    function automatic word_t fmt_rdata(acc_width_t width, logic [1:0] off, word_t data);
        word_t res;
        res = '0;
        case (width)
            ACC_BYTE: begin
                case (off)
                    2'd0:    res[7:0] = data[7:0];
                    2'd1:    res[7:0] = data[15:8];
                    2'd2:    res[7:0] = data[23:16];
                    default: res[7:0] = data[31:24];
                endcase
            end
            ACC_HALF: res[15:0] = off[1] ? data[31:16] : data[15:0];
            default:  res = data;      // Word
        endcase
        return res;
    endfunction

    // ------------------------------
    // Outputs
    // ------------------------------
    assign cpu_req_ack_o  = (state == IDLE) && cpu_req_i;
    assign cpu_resp_o     = (state == RESPOND);
    assign cmp_tag_o      = req_q.addr[TAG_MSB:TAG_LSB];
    assign refill_start_o = (state == TAG_COMPARE) && !hit_i;  // Miss
    assign refill_addr_o  = req_q.addr;
    assign ram_raddr_o    = raddr_q;

    assign rdata_fmt   = fmt_rdata(req_q.width, req_q.addr[1:0], ram_rdata_i);
    assign cpu_rdata_o = (state == RESPOND) ? rdata_fmt : rdata_q;  // Hold after resp

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            rdata_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req_i) begin
                        state <= TAG_COMPARE;
                    end
                end
                TAG_COMPARE: begin
                    state <= hit_i ? RAM_READ : REFILL_WAIT;
                end
                RAM_READ: begin
                    state <= RESPOND;     // Array output lands next cycle
                end
                RESPOND: begin
                    rdata_q <= rdata_fmt;
                    state   <= IDLE;
                end
                REFILL_WAIT: begin
                    if (!refill_busy_i) begin
                        state <= TAG_COMPARE;  // Line installed, look up again
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and read address capture
    always_ff @(posedge mclk) begin
        if (cpu_req_ack_o) begin
            req_q <= cpu_req_data_i;
        end
        if ((state == TAG_COMPARE) && hit_i) begin
            raddr_q <= {hit_idx_i, word_ptr_t'(req_q.addr[TAG_LSB-1:2])};
        end
    end

    // Data only goes out once the refill engine is done, and for a single cycle
    a_resp_single : assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_resp_o |-> !refill_busy_i ##1 !cpu_resp_o)
        else $error("ctrl: response during a refill or longer than one cycle");

    // Refill only from an idle engine, which must answer with busy
    a_refill_start : assert property (@(posedge mclk) disable iff (!rst_n)
        refill_start_o |-> ((state != REFILL_WAIT) && !refill_busy_i) ##1 refill_busy_i)
        else $error("ctrl: refill start while a refill is pending");

endmodule

// File: src/icache_data_ram.sv
// 2 KB cache data array, one write port for refill and one registered read port for lookups

`timescale 1ns/10ps

module icache_data_ram
    import icache_pkg::*;
(
    input  logic      mclk,
    input  ram_wr_t   ram_wr_i,      // Refill write
    input  ram_addr_t raddr_i,       // Lookup read address
    output word_t     rdata_o        // Valid one cycle after raddr_i
);

    // ------------------------------
    // Storage, 16 lines x 32 words
    // ------------------------------
    word_t mem [NUM_LINES*LINE_WORDS];

    always_ff @(posedge mclk) begin
        if (ram_wr_i.wr_en) begin
            mem[ram_wr_i.addr] <= ram_wr_i.data;
        end
    end

    // Registered read, like the SRAM macro output latch
    always_ff @(posedge mclk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: src/icache_pkg.sv
// Shared geometry, vector types, bundles and FSM states, imported by every cache block

package icache_pkg;

    // ------------------------------
    // Cache geometry
    // ------------------------------
    localparam int NUM_LINES  = 16;            // Lines in the cache
    localparam int LINE_WORDS = 32;            // Words per line, also the refill burst length
    localparam int TAG_LSB    = 7;             // Tag field low bit
    localparam int TAG_MSB    = 26;            // Tag field high bit

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [31:0] addr_t;               // Byte address
    typedef logic [31:0] word_t;               // Data word
    typedef logic [TAG_MSB-TAG_LSB:0] tag_t;   // 20-bit line tag
    typedef logic [3:0]  line_idx_t;           // Line number
    typedef logic [4:0]  word_ptr_t;           // Word within a line
    typedef logic [8:0]  ram_addr_t;           // {line, word} into the data array
    typedef logic [1:0]  acc_width_t;          // 0 byte, 1 halfword, 2 word
    typedef logic [9:0]  burst_len_t;          // Memory bus burst length

    // Access width codes
    localparam acc_width_t ACC_BYTE = 2'd0;
    localparam acc_width_t ACC_HALF = 2'd1;
    localparam acc_width_t ACC_WORD = 2'd2;

    // ------------------------------
    // Bundles
    // ------------------------------
    typedef struct packed {
        addr_t      addr;                      // Requested byte address
        acc_width_t width;                     // Access width code
    } cpu_req_t;                               // 34 bits

    typedef struct packed {
        logic       wr_en;                     // Write strobe
        ram_addr_t  addr;                      // Target word
        word_t      data;                      // Refill word
    } ram_wr_t;                                // 42 bits

    typedef struct packed {
        logic       wr_en;                     // Install at the FIFO pointer
        tag_t       tag;                       // Tag of the new line
    } tag_wr_t;                                // 21 bits

    // Lookup controller states
    typedef enum logic [2:0] {
        IDLE,
        TAG_COMPARE,
        RAM_READ,
        RESPOND,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

// File: src/icache_refill.sv
// Line refill engine: fetches one 32-word burst into the data array and installs the tag

`timescale 1ns/10ps

module icache_refill
    import icache_pkg::*;
(
    input  logic       mclk,
    input  logic       rst_n,
    input  logic       refill_start_i,   // One-cycle start from the controller
    input  addr_t      refill_addr_i,    // Missing address
    input  line_idx_t  fill_idx_i,       // Victim line from the tag store
    output logic       refill_busy_o,
    // Memory bus
    output logic       mem_stb_o,
    output addr_t      mem_adr_o,
    output burst_len_t mem_bl_o,
    input  word_t      mem_dat_i,
    input  logic       mem_ack_i,
    input  logic       mem_lack_i,       // Marks the final ack of the burst
    // Array side
    output ram_wr_t    ram_wr_o,
    output tag_wr_t    tag_wr_o
);

    logic      active_q;                  // Burst in progress
    addr_t     line_addr_q;               // Line-aligned burst address
    line_idx_t fill_idx_q;                // Victim held for the whole burst
    word_ptr_t word_ptr_q;                // Next word position in the line
    logic      beat;
    logic      last_beat;

    assign beat      = active_q && mem_ack_i;
    assign last_beat = beat && mem_lack_i;

    // ------------------------------
    // Burst control
    // ------------------------------
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            active_q   <= 1'b0;
            word_ptr_q <= '0;
        end else if (!active_q) begin
            if (refill_start_i) begin
                active_q   <= 1'b1;       // Strobe up the cycle after start
                word_ptr_q <= '0;
            end
        end else begin
            if (beat) begin
                word_ptr_q <= word_ptr_q + 1'b1;
            end
            if (last_beat) begin
                active_q <= 1'b0;         // Drop strobe after the last ack
            end
        end
    end

    // Request payload captured at start
    always_ff @(posedge mclk) begin
        if (refill_start_i && !active_q) begin
            line_addr_q <= {refill_addr_i[$bits(addr_t)-1:TAG_LSB], {TAG_LSB{1'b0}}};
            fill_idx_q  <= fill_idx_i;
        end
    end

    assign refill_busy_o = active_q;
    assign mem_stb_o     = active_q;
    assign mem_adr_o     = line_addr_q;
    assign mem_bl_o      = burst_len_t'(LINE_WORDS);  // Always a full line

    // One array write per ack, in address order
    assign ram_wr_o.wr_en = beat;
    assign ram_wr_o.addr  = {fill_idx_q, word_ptr_q};
    assign ram_wr_o.data  = mem_dat_i;

    // Tag goes in with the last word
    assign tag_wr_o.wr_en = last_beat;
    assign tag_wr_o.tag   = line_addr_q[TAG_MSB:TAG_LSB];

    a_ack_in_burst : assert property (@(posedge mclk) disable iff (!rst_n)
        mem_ack_i |-> mem_stb_o)
        else $error("refill: memory ack outside a burst");

endmodule

// File: src/icache_tag_store.sv
// Fully associative tag array with FIFO replacement, instantiated once by the cache top

`timescale 1ns/10ps

module icache_tag_store
    import icache_pkg::*;
(
    input  logic      mclk,
    input  logic      rst_n,
    input  tag_t      cmp_tag_i,     // Tag of the pending request
    input  tag_wr_t   tag_wr_i,      // Install from the refill engine
    output logic      hit_o,
    output line_idx_t hit_idx_o,
    output line_idx_t fill_idx_o     // Next victim line
);

    logic [NUM_LINES-1:0] valid_q;   // Per-line valid
    tag_t                 tag_q [NUM_LINES];
    line_idx_t            fill_ptr_q; // Oldest line, replaced next
    logic [NUM_LINES-1:0] match;

    // ------------------------------
    // Parallel compare
    // ------------------------------
    always_comb begin
        match     = '0;
        hit_idx_o = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (valid_q[i] && (tag_q[i] == cmp_tag_i)) begin
                match[i]  = 1'b1;
                hit_idx_o = line_idx_t'(i);  // Encode matching line
            end
        end
    end

    assign hit_o      = |match;
    assign fill_idx_o = fill_ptr_q;

    // Valid bits and FIFO pointer
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            fill_ptr_q <= '0;
        end else if (tag_wr_i.wr_en) begin
            valid_q[fill_ptr_q] <= 1'b1;
            fill_ptr_q          <= fill_ptr_q + 1'b1;  // Wraps after line 15
        end
    end

    // Tag payload
    always_ff @(posedge mclk) begin
        if (tag_wr_i.wr_en) begin
            tag_q[fill_ptr_q] <= tag_wr_i.tag;
        end
    end

    // A line is only installed after a miss on its tag, so no tag lives twice
    a_single_match : assert property (@(posedge mclk) disable iff (!rst_n)
        $onehot0(match))
        else $error("tag store: more than one line matches");

endmodule

// File: src/icache_top.sv
// Instruction cache top: CPU fetch port in, burst memory bus out, blocks wired together

`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
(
    input  logic       mclk,
    input  logic       rst_n,
    // CPU fetch port
    input  logic       cpu_req_i,
    input  cpu_req_t   cpu_req_data_i,
    output logic       cpu_req_ack_o,
    output logic       cpu_resp_o,
    output word_t      cpu_rdata_o,
    // Main memory burst bus
    output logic       mem_stb_o,
    output addr_t      mem_adr_o,
    output burst_len_t mem_bl_o,
    input  word_t      mem_dat_i,
    input  logic       mem_ack_i,
    input  logic       mem_lack_i
);

    // ------------------------------
    // Internal links
    // ------------------------------
    tag_t      cmp_tag;
    logic      hit;
    line_idx_t hit_idx;
    line_idx_t fill_idx;            // FIFO victim
    logic      refill_start;
    addr_t     refill_addr;
    logic      refill_busy;
    ram_addr_t ram_raddr;
    word_t     ram_rdata;
    ram_wr_t   ram_wr;
    tag_wr_t   tag_wr;

    icache_ctrl u_ctrl (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .cpu_req_i      (cpu_req_i),
        .cpu_req_data_i (cpu_req_data_i),
        .cpu_req_ack_o  (cpu_req_ack_o),
        .cpu_resp_o     (cpu_resp_o),
        .cpu_rdata_o    (cpu_rdata_o),
        .cmp_tag_o      (cmp_tag),
        .hit_i          (hit),
        .hit_idx_i      (hit_idx),
        .refill_start_o (refill_start),
        .refill_addr_o  (refill_addr),
        .refill_busy_i  (refill_busy),
        .ram_raddr_o    (ram_raddr),
        .ram_rdata_i    (ram_rdata)
    );

    icache_tag_store u_tag_store (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .cmp_tag_i  (cmp_tag),
        .tag_wr_i   (tag_wr),
        .hit_o      (hit),
        .hit_idx_o  (hit_idx),
        .fill_idx_o (fill_idx)
    );

    icache_refill u_refill (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .refill_start_i (refill_start),
        .refill_addr_i  (refill_addr),
        .fill_idx_i     (fill_idx),
        .refill_busy_o  (refill_busy),
        .mem_stb_o      (mem_stb_o),
        .mem_adr_o      (mem_adr_o),
        .mem_bl_o       (mem_bl_o),
        .mem_dat_i      (mem_dat_i),
        .mem_ack_i      (mem_ack_i),
        .mem_lack_i     (mem_lack_i),
        .ram_wr_o       (ram_wr),
        .tag_wr_o       (tag_wr)
    );

    icache_data_ram u_data_ram (
        .mclk     (mclk),
        .ram_wr_i (ram_wr),
        .raddr_i  (ram_raddr),
        .rdata_o  (ram_rdata)
    );

endmodule

// File: testbench/icache_stim.txt
# Columns: hex byte address, width code (0 byte, 1 halfword, 2 word),
# expected hex read data, 1 if the request must start exactly one refill burst
# Cold miss on line 0, then hits in the same line
00012304 2 5A5B2304 1
00012378 2 5A5B2378 0
00012340 0 00000040 0
00012341 0 00000023 0
00012342 0 0000005B 0
00012343 0 0000005A 0
00012350 1 00002350 0
00012352 1 00005A5B 0
# Sixteen more lines, the last one evicts line 0
00113304 2 5A4B3304 1
00214308 2 5A7B4308 1
0031530C 2 5A6B530C 1
00416310 2 5A1B6310 1
00517314 2 5A0B7314 1
00618318 2 5A3B8318 1
0071931E 1 00005A2B 1
0081A320 2 5ADBA320 1
0091B325 0 000000B3 1
00A1C328 2 5AFBC328 1
00B1D32C 2 5AEBD32C 1
00C1E330 2 5A9BE330 1
00D1F334 2 5A8BF334 1
00E20338 2 5AB80338 1
00F2133C 2 5AA8133C 1
01022340 2 5B582340 1
# Line 0 refills into the oldest slot, which held line 1
0001237C 2 5A5B237C 1
00214370 2 5A7B4370 0
01022302 1 00005B58 0
00012301 0 00000023 0
# Line 1 is gone, its refill evicts line 2
00113300 2 5A4B3300 1
0031537C 2 5A6B537C 0
00214300 2 5A7B4300 1

// File: testbench/tb_icache.sv
// Cache testbench top: replays CPU fetches from the stim file against the burst memory model

`timescale 1ns/10ps

module tb_icache
    import icache_pkg::*;
();

    localparam int    CLK_HALF       = 5;                    // 10 ns period
    localparam int    RESET_CYCLES   = 10;
    localparam int    MAX_REQ        = 64;                   // Stim table depth
    localparam int    CYCLES_PER_REQ = LINE_WORDS * 4 + 20;  // Worst refill plus lookup
    localparam int    HIT_LATENCY    = 3;                    // Ack to resp on a hit
    localparam string STIM_FILE      = "testbench/icache_stim.txt";

    logic       mclk;
    logic       rst_n;
    logic       cpu_req_i;
    cpu_req_t   cpu_req_data_i;
    logic       cpu_req_ack_o;
    logic       cpu_resp_o;
    word_t      cpu_rdata_o;
    logic       mem_stb_o;
    addr_t      mem_adr_o;
    burst_len_t mem_bl_o;
    word_t      mem_dat_i;
    logic       mem_ack_i;
    logic       mem_lack_i;

    // Stim table
    addr_t      stim_addr   [MAX_REQ];
    acc_width_t stim_width  [MAX_REQ];
    word_t      stim_data   [MAX_REQ];
    logic       stim_refill [MAX_REQ];
    int         n_req = 0;

    int         cycle       = 0;
    int         cycle_limit = MAX_REQ * CYCLES_PER_REQ + RESET_CYCLES;
    int         burst_cnt   = 0;       // Strobe rises during the current request
    logic       stb_seen    = 1'b0;
    addr_t      exp_line_addr = '0;

    icache_top u_dut (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .cpu_req_i      (cpu_req_i),
        .cpu_req_data_i (cpu_req_data_i),
        .cpu_req_ack_o  (cpu_req_ack_o),
        .cpu_resp_o     (cpu_resp_o),
        .cpu_rdata_o    (cpu_rdata_o),
        .mem_stb_o      (mem_stb_o),
        .mem_adr_o      (mem_adr_o),
        .mem_bl_o       (mem_bl_o),
        .mem_dat_i      (mem_dat_i),
        .mem_ack_i      (mem_ack_i),
        .mem_lack_i     (mem_lack_i)
    );

    tb_mem_model u_mem (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .mem_stb_i  (mem_stb_o),
        .mem_adr_i  (mem_adr_o),
        .mem_bl_i   (mem_bl_o),
        .mem_dat_o  (mem_dat_i),
        .mem_ack_o  (mem_ack_i),
        .mem_lack_o (mem_lack_i)
    );

    initial mclk = 1'b0;
    always #CLK_HALF mclk = ~mclk;

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input burst_len_t got, input burst_len_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%03h, expected 0x%03h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // ------------------------------
    // Monitors
    // ------------------------------
    always @(posedge mclk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            stop_on_error($sformatf("Run timed out after %0d cycles", cycle));
        end
    end

    // New burst: line-aligned address, full line length
    always @(posedge mclk) begin
        if (mem_stb_o && !stb_seen) begin
            burst_cnt = burst_cnt + 1;
            check_addr("mem_adr_o", mem_adr_o, exp_line_addr);
            check_len("mem_bl_o", mem_bl_o, burst_len_t'(LINE_WORDS));
        end
        stb_seen <= mem_stb_o;
    end

    // Comment lines start with #
    task automatic load_stim();
        int    fd;
        int    code;
        int    w;
        int    r;
        string line;
        addr_t a;
        word_t d;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stim file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 3 && line[0] != "#") begin
                code = $sscanf(line, "%h %d %h %d", a, w, d, r);
                if (code != 4 || n_req >= MAX_REQ) begin
                    stop_on_error("Stim file line is malformed or the table is full");
                end
                stim_addr[n_req]   = a;
                stim_width[n_req]  = acc_width_t'(w);
                stim_data[n_req]   = d;
                stim_refill[n_req] = (r != 0);
                n_req = n_req + 1;
            end
        end
        $fclose(fd);
    endtask

    // One fetch, from request to the held data after resp
    task automatic run_request(input int idx);
        int    ack_cyc;
        int    resp_cyc;
        word_t rdata;
        @(negedge mclk);
        exp_line_addr        = {stim_addr[idx][31:TAG_LSB], {TAG_LSB{1'b0}}};
        burst_cnt            = 0;
        cpu_req_data_i.addr  = stim_addr[idx];
        cpu_req_data_i.width = stim_width[idx];
        cpu_req_i            = 1'b1;
        @(posedge mclk);
        while (!cpu_req_ack_o) @(posedge mclk);
        ack_cyc = cycle;
        @(negedge mclk);
        cpu_req_i = 1'b0;                          // Level dropped once accepted
        @(posedge mclk);
        while (!cpu_resp_o) @(posedge mclk);
        resp_cyc = cycle;
        rdata    = cpu_rdata_o;
        @(negedge mclk);
        check_word("cpu_rdata_o", rdata, stim_data[idx]);
        check_word("cpu_rdata_o after resp", cpu_rdata_o, stim_data[idx]);
        if (burst_cnt > 1) begin
            stop_on_error($sformatf("Request %0d started more than one burst", idx));
        end
        check_flag("refill burst", burst_cnt != 0, stim_refill[idx]);
        if (!stim_refill[idx]) begin
            check_latency("ack to resp cycles", resp_cyc - ack_cyc, HIT_LATENCY);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n          = 1'b0;
        cpu_req_i      = 1'b0;
        cpu_req_data_i = '0;
        load_stim();
        cycle_limit = n_req * CYCLES_PER_REQ + RESET_CYCLES + 4;
        repeat (RESET_CYCLES) @(posedge mclk);
        @(negedge mclk);
        rst_n = 1'b1;
        @(posedge mclk);
        check_flag("cpu_req_ack_o", cpu_req_ack_o, 1'b0);  // Quiet after reset
        check_flag("cpu_resp_o", cpu_resp_o, 1'b0);
        check_flag("mem_stb_o", mem_stb_o, 1'b0);
        for (int i = 0; i < n_req; i++) begin
            run_request(i);
        end
        if (n_req > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_error("The stim file held no requests");
        end
    end

endmodule

// File: testbench/tb_mem_model.sv
// Burst memory model for the cache testbench, answers line refills with address-derived words

`timescale 1ns/10ps

module tb_mem_model
    import icache_pkg::*;
(
    input  logic       mclk,
    input  logic       rst_n,
    input  logic       mem_stb_i,
    input  addr_t      mem_adr_i,
    input  burst_len_t mem_bl_i,
    output word_t      mem_dat_o,
    output logic       mem_ack_o,
    output logic       mem_lack_o       // With the final beat
);

    localparam word_t       DATA_KEY  = 32'h5A5A_0000;  // Word at A is A ^ key
    localparam logic [15:0] LFSR_SEED = 16'd13;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;       // x^16 + x^14 + x^13 + x^11 + 1

    logic [15:0] lfsr;

    // Galois step, one per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return {a[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    // Two random bits give 0 to 3 idle cycles
    task automatic take_wait(output int cycles);
        cycles = 0;
        for (int b = 0; b < 2; b++) begin
            cycles = cycles | (int'(lfsr[0]) << b);
            lfsr   = lfsr_step(lfsr);
        end
    endtask

    initial begin
        mem_dat_o  = '0;
        mem_ack_o  = 1'b0;
        mem_lack_o = 1'b0;
        lfsr       = LFSR_SEED;
    end

    // ------------------------------
    // Burst responder, falling edge
    // ------------------------------
    always begin : serve_bursts
        addr_t beat_addr;
        int    n_beats;
        int    wait_cycles;
        @(negedge mclk);
        if (rst_n && mem_stb_i) begin
            beat_addr = mem_adr_i;
            n_beats   = int'(mem_bl_i);
            for (int i = 0; i < n_beats; i++) begin
                take_wait(wait_cycles);
                repeat (wait_cycles) @(negedge mclk);   // Idle gap before the beat
                mem_dat_o  = mem_word(beat_addr);
                mem_ack_o  = 1'b1;
                mem_lack_o = (i == n_beats - 1);
                @(negedge mclk);
                mem_ack_o  = 1'b0;
                mem_lack_o = 1'b0;
                beat_addr  = beat_addr + 32'd4;         // Address order
            end
        end
    end

endmodule

// File: verilog.f
src/icache_pkg.sv
src/icache_tag_store.sv
src/icache_data_ram.sv
src/icache_refill.sv
src/icache_ctrl.sv
src/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache.sv
